// File: Bender.yml
package:
  name: blit

sources:
  - include_dirs:
      - hw
    files:
      - hw/blit_pkg.sv
      - hw/rect_walker.sv
      - hw/texel_address.sv
      - hw/axil_texel_fetch.sv
      - hw/blit_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/axil_mem_model.sv
      - dv/blit_assertions.sv
      - dv/blit_tb.sv

// File: blit.f
+incdir+hw
hw/blit_pkg.sv
hw/rect_walker.sv
hw/texel_address.sv
hw/axil_texel_fetch.sv
hw/blit_top.sv
dv/axil_mem_model.sv
dv/blit_assertions.sv
dv/blit_tb.sv

// File: dv/axil_mem_model.sv
`timescale 1ns/1ps

module axil_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  blit_pkg::addr_t      araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output blit_pkg::axi_data_t  rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    logic            busy;      // read accepted, data not yet taken
    int              ar_wait;
    int              r_wait;
    blit_pkg::addr_t word_addr;

    assign rresp     = 2'b00;
    assign word_addr = {araddr[31:2], 2'b00};

    initial begin
        void'($urandom(32'h685f_0e94));
        forever begin
            @(posedge clk);
            if (rst) begin
                arready <= 1'b0;
                rvalid  <= 1'b0;
                rdata   <= '0;
                busy    <= 1'b0;
                ar_wait <= 0;
                r_wait  <= 0;
            end else begin
                arready <= 1'b0;    // one-cycle pulse
                if (arvalid && arready) begin
                    rdata  <= {~word_addr[15:0], word_addr[15:0]};
                    busy   <= 1'b1;
                    r_wait <= $urandom % 4;
                end else if (arvalid && !busy) begin
                    if (ar_wait == 0) begin
                        arready <= 1'b1;
                        ar_wait <= $urandom % 4;
                    end else begin
                        ar_wait <= ar_wait - 1;
                    end
                end
                if (busy && !rvalid) begin
                    if (r_wait == 0)
                        rvalid <= 1'b1;
                    else
                        r_wait <= r_wait - 1;
                end
                if (rvalid && rready) begin
                    rvalid <= 1'b0;
                    busy   <= 1'b0;
                end
            end
        end
    end

endmodule

// File: dv/blit_assertions.sv
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_assertions (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_ready,
    input  logic              m_axil_arvalid,
    input  logic              m_axil_arready,
    input  blit_pkg::addr_t   m_axil_araddr,
    input  logic              fb_write,
    input  blit_pkg::coord_t  fb_x,
    input  blit_pkg::coord_t  fb_y
);

    int failures = 0;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
        else begin
            failures++;
            $error("arvalid or araddr changed before arready");
        end

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid |-> m_axil_araddr[1:0] == 2'b00)
        else begin
            failures++;
            $error("read address not word aligned");
        end

    fb_in_bounds: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> int'(fb_x) < `BLIT_FB_WIDTH && int'(fb_y) < `BLIT_FB_HEIGHT)
        else begin
            failures++;
            $error("framebuffer write outside the screen");
        end

    // registered ready, so checked one edge after reset is seen
    ready_in_reset: assert property (@(posedge clk) rst |=> !cmd_ready)
        else begin
            failures++;
            $error("cmd_ready high during reset");
        end

endmodule

// File: dv/blit_tb.sv
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_tb;

    localparam int NUM_ROWS   = 12;
    localparam int WAIT_LIMIT = 500;

    typedef struct {
        blit_pkg::coord_t  dst_x;
        blit_pkg::coord_t  dst_y;
        blit_pkg::coord_t  width;
        blit_pkg::coord_t  height;
        blit_pkg::coord_t  src_x;
        blit_pkg::coord_t  src_y;
        blit_pkg::addr_t   image_base;
        blit_pkg::coord_t  image_stride;
        logic              mirror_x;
        logic              mirror_y;
        logic              fill_mode;
        blit_pkg::colour_t fill_colour;
        logic              drain;       // wait for all writes before the next row
        int                exp_count;
    } blit_cmd_t;

    logic                clk;
    logic                rst;
    logic                cmd_valid;
    logic                cmd_ready;
    blit_pkg::coord_t    dst_x;
    blit_pkg::coord_t    dst_y;
    blit_pkg::coord_t    width;
    blit_pkg::coord_t    height;
    blit_pkg::coord_t    src_x;
    blit_pkg::coord_t    src_y;
    blit_pkg::addr_t     image_base;
    blit_pkg::coord_t    image_stride;
    logic                mirror_x;
    logic                mirror_y;
    logic                fill_mode;
    blit_pkg::colour_t   fill_colour;
    blit_pkg::addr_t     m_axil_araddr;
    logic [2:0]          m_axil_arprot;
    logic                m_axil_arvalid;
    logic                m_axil_arready;
    blit_pkg::axi_data_t m_axil_rdata;
    logic [1:0]          m_axil_rresp;
    logic                m_axil_rvalid;
    logic                m_axil_rready;
    blit_pkg::coord_t    fb_x;
    blit_pkg::coord_t    fb_y;
    blit_pkg::colour_t   fb_colour;
    logic                fb_write;

    blit_cmd_t         table_rows [NUM_ROWS];
    blit_pkg::coord_t  exp_x [$];
    blit_pkg::coord_t  exp_y [$];
    blit_pkg::colour_t exp_colour [$];
    int                exp_row [$];
    int                seen [NUM_ROWS];
    int                value_errors;
    int                timeout_errors;
    int                total_expected;
    int                total_seen;
    int                row_idx;

    blit_top dut0 (.*);

    axil_mem_model mem0 (
        .clk     (clk),
        .rst     (rst),
        .araddr  (m_axil_araddr),
        .arvalid (m_axil_arvalid),
        .arready (m_axil_arready),
        .rdata   (m_axil_rdata),
        .rresp   (m_axil_rresp),
        .rvalid  (m_axil_rvalid),
        .rready  (m_axil_rready)
    );

    bind blit_top blit_assertions assert0 (
        .clk            (clk),
        .rst            (rst),
        .cmd_ready      (cmd_ready),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_araddr  (m_axil_araddr),
        .fb_write       (fb_write),
        .fb_x           (fb_x),
        .fb_y           (fb_y)
    );

    always #2 clk = ~clk;

    function automatic blit_cmd_t make_cmd(int dx, int dy, int w, int h, int sx, int sy,
                                           blit_pkg::addr_t base, int stride,
                                           bit mx, bit my, bit fill,
                                           blit_pkg::colour_t colour, bit drain, int count);
        blit_cmd_t c;
        c.dst_x        = dx;
        c.dst_y        = dy;
        c.width        = w;
        c.height       = h;
        c.src_x        = sx;
        c.src_y        = sy;
        c.image_base   = base;
        c.image_stride = stride;
        c.mirror_x     = mx;
        c.mirror_y     = my;
        c.fill_mode    = fill;
        c.fill_colour  = colour;
        c.drain        = drain;
        c.exp_count    = count;
        return c;
    endfunction

    task automatic load_table();
        table_rows[0]  = make_cmd(10, 20, 5, 3, 0, 0, 32'h0, 0, 0, 0, 1, 16'hf81f, 1, 15);
        table_rows[1]  = make_cmd(50, 60, 4, 2, 3, 5, 32'h0001_0000, 64, 0, 0, 0, 0, 1, 8);
        table_rows[2]  = make_cmd(100, 100, 3, 2, 2, 1, 32'h0002_0002, 40, 1, 0, 0, 0, 1, 6);
        table_rows[3]  = make_cmd(30, 40, 2, 3, 0, 0, 32'h0, 0, 0, 1, 1, 16'h07e0, 1, 6);
        table_rows[4]  = make_cmd(200, 150, 3, 3, 7, 9, 32'h0003_0000, 100, 1, 1, 0, 0, 1, 9);
        table_rows[5]  = make_cmd(398, 238, 4, 4, 0, 0, 32'h0, 0, 0, 0, 1, 16'h001f, 1, 4);
        table_rows[6]  = make_cmd(0, 0, 0, 5, 0, 0, 32'h0, 0, 0, 0, 1, 16'hffff, 1, 0);
        table_rows[7]  = make_cmd(398, 238, 4, 4, 1, 1, 32'h0000_4000, 16, 1, 0, 0, 0, 1, 4);
        // back to back from here
        table_rows[8]  = make_cmd(0, 0, 3, 2, 0, 0, 32'h0, 0, 1, 0, 1, 16'ha5a5, 0, 6);
        table_rows[9]  = make_cmd(390, 10, 5, 1, 1, 2, 32'h0000_8000, 320, 0, 0, 0, 0, 0, 5);
        table_rows[10] = make_cmd(399, 239, 1, 1, 0, 0, 32'h0, 0, 1, 1, 1, 16'h1234, 0, 1);
        table_rows[11] = make_cmd(5, 230, 2, 3, 0, 0, 32'h0000_8006, 11, 0, 0, 0, 0, 1, 6);
    endtask

    // expected writes in walk order, image data from the memory rule
    task automatic push_expected(input int row);
        blit_cmd_t         c;
        int                px;
        int                py;
        int                dx;
        int                dy;
        blit_pkg::addr_t   a;
        logic [15:0]       low;
        blit_pkg::colour_t col;
        c = table_rows[row];
        for (py = 0; py < c.height; py++) begin
            for (px = 0; px < c.width; px++) begin
                dx = c.mirror_x ? c.dst_x + c.width - 1 - px : c.dst_x + px;
                dy = c.mirror_y ? c.dst_y + c.height - 1 - py : c.dst_y + py;
                if (dx < `BLIT_FB_WIDTH && dy < `BLIT_FB_HEIGHT) begin
                    a   = c.image_base + 2 * (c.src_x + px + c.image_stride * (c.src_y + py));
                    low = a[15:0] & 16'hfffc;
                    col = a[1] ? ~low : low;
                    exp_x.push_back(dx);
                    exp_y.push_back(dy);
                    exp_colour.push_back(c.fill_mode ? c.fill_colour : col);
                    exp_row.push_back(row);
                    total_expected++;
                end
            end
        end
    endtask

    task automatic wait_cmd_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (cmd_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ready !== 1'b1) begin
            timeout_errors++;
            $display("Timed out waiting for the command port to become ready");
        end
    endtask

    task automatic send_command(input int row);
        push_expected(row);
        dst_x        = table_rows[row].dst_x;
        dst_y        = table_rows[row].dst_y;
        width        = table_rows[row].width;
        height       = table_rows[row].height;
        src_x        = table_rows[row].src_x;
        src_y        = table_rows[row].src_y;
        image_base   = table_rows[row].image_base;
        image_stride = table_rows[row].image_stride;
        mirror_x     = table_rows[row].mirror_x;
        mirror_y     = table_rows[row].mirror_y;
        fill_mode    = table_rows[row].fill_mode;
        fill_colour  = table_rows[row].fill_colour;
        cmd_valid    = 1'b1;
        wait_cmd_ready();   // handshake on the next rising edge
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // timeout restarts with every write seen
    task automatic wait_writes();
        int idle;
        int last;
        idle = 0;
        last = total_seen;
        while (total_seen < total_expected && idle < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            if (total_seen != last) begin
                idle = 0;
                last = total_seen;
            end else begin
                idle++;
            end
        end
        if (total_seen < total_expected) begin
            timeout_errors++;
            $display("Timed out waiting for a framebuffer write, %0d of %0d seen",
                     total_seen, total_expected);
        end
    endtask

    always @(negedge clk) begin : check_writes
        int                row;
        blit_pkg::coord_t  ex;
        blit_pkg::coord_t  ey;
        blit_pkg::colour_t ec;
        if (!rst && fb_write === 1'b1) begin
            assert (exp_x.size() != 0) else begin
                value_errors++;
                $display("ERR %0t: unexpected write at (%0d,%0d)", $time, fb_x, fb_y);
            end
            if (exp_x.size() != 0) begin
                row = exp_row.pop_front();
                ex  = exp_x.pop_front();
                ey  = exp_y.pop_front();
                ec  = exp_colour.pop_front();
                seen[row]++;
                total_seen++;
                assert (fb_x === ex && fb_y === ey) else begin
                    value_errors++;
                    $display("ERR %0t: row %0d write at (%0d,%0d), expected (%0d,%0d)",
                             $time, row, fb_x, fb_y, ex, ey);
                end
                assert (fb_colour === ec) else begin
                    value_errors++;
                    $display("ERR %0t: row %0d colour %h at (%0d,%0d), expected %h",
                             $time, row, fb_colour, fb_x, fb_y, ec);
                end
            end
        end
    end

    always @(negedge clk) begin : check_read_prot
        if (!rst && m_axil_arvalid === 1'b1) begin
            assert (m_axil_arprot === 3'b000) else begin
                value_errors++;
                $display("ERR %0t: arprot %b on a read, expected 000", $time, m_axil_arprot);
            end
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        cmd_valid      = 1'b0;
        dst_x          = '0;
        dst_y          = '0;
        width          = '0;
        height         = '0;
        src_x          = '0;
        src_y          = '0;
        image_base     = '0;
        image_stride   = '0;
        mirror_x       = 1'b0;
        mirror_y       = 1'b0;
        fill_mode      = 1'b0;
        fill_colour    = '0;
        value_errors   = 0;
        timeout_errors = 0;
        total_expected = 0;
        total_seen     = 0;
        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++)
            seen[row_idx] = 0;
        load_table();

        repeat (8) @(posedge clk);
        #1;
        assert (cmd_ready === 1'b0 && fb_write === 1'b0 && m_axil_arvalid === 1'b0) else begin
            value_errors++;
            $display("ERR %0t: outputs not idle during reset", $time);
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        assert (cmd_ready === 1'b1) else begin
            value_errors++;
            $display("ERR %0t: cmd_ready not high one cycle after reset", $time);
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            assert (fb_write === 1'b0 && m_axil_arvalid === 1'b0) else begin
                value_errors++;
                $display("ERR %0t: write or read before the first command", $time);
            end
        end

        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            send_command(row_idx);
            if (table_rows[row_idx].drain)
                wait_writes();
        end
        wait_writes();
        wait_cmd_ready();

        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            assert (seen[row_idx] == table_rows[row_idx].exp_count) else begin
                value_errors++;
                $display("ERR %0t: row %0d wrote %0d pixels, expected %0d",
                         $time, row_idx, seen[row_idx], table_rows[row_idx].exp_count);
            end
        end

        $display("value errors %0d, timeouts %0d, assertion failures %0d",
                 value_errors, timeout_errors, dut0.assert0.failures);
        if (value_errors + timeout_errors + dut0.assert0.failures == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: hw/axil_texel_fetch.sv
`timescale 1ns/1ps
`include "blit_defs.svh"

module axil_texel_fetch (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 tex_valid,
    output logic                 tex_ready,
    input  blit_pkg::addr_t      tex_addr,
    input  blit_pkg::coord_t     tex_dst_x,
    input  blit_pkg::coord_t     tex_dst_y,
    input  logic                 tex_fill,
    input  blit_pkg::colour_t    tex_colour,

    output blit_pkg::addr_t      m_axil_araddr,
    output logic [2:0]           m_axil_arprot,
    output logic                 m_axil_arvalid,
    input  logic                 m_axil_arready,
    input  blit_pkg::axi_data_t  m_axil_rdata,
    input  logic [1:0]           m_axil_rresp,
    input  logic                 m_axil_rvalid,
    output logic                 m_axil_rready,

    output blit_pkg::coord_t     fb_x,
    output blit_pkg::coord_t     fb_y,
    output blit_pkg::colour_t    fb_colour,
    output logic                 fb_write
);

    blit_pkg::fetch_state_t state;

    logic tex_fire;
    logic ar_fire;
    logic r_fire;
    logic half_q;   // address bit 1 of the pending read

    // accept a new item while idle or during the write pulse
    assign tex_ready      = (state == blit_pkg::FETCH_IDLE) || (state == blit_pkg::FETCH_WRITE);
    assign m_axil_arvalid = (state == blit_pkg::FETCH_ADDR);
    assign m_axil_rready  = (state == blit_pkg::FETCH_DATA);
    assign fb_write       = (state == blit_pkg::FETCH_WRITE);
    assign m_axil_arprot  = 3'b000;

    assign tex_fire = tex_valid && tex_ready;
    assign ar_fire  = m_axil_arvalid && m_axil_arready;
    assign r_fire   = m_axil_rvalid && m_axil_rready;   // rresp not checked

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= blit_pkg::FETCH_IDLE;
        end else begin
            case (state)
                blit_pkg::FETCH_IDLE, blit_pkg::FETCH_WRITE: begin
                    if (tex_fire)
                        state <= tex_fill ? blit_pkg::FETCH_WRITE : blit_pkg::FETCH_ADDR;
                    else
                        state <= blit_pkg::FETCH_IDLE;
                end
                blit_pkg::FETCH_ADDR: if (ar_fire) state <= blit_pkg::FETCH_DATA;
                blit_pkg::FETCH_DATA: if (r_fire) state <= blit_pkg::FETCH_WRITE;
            endcase
        end
    end

    // destination loads at accept, the write pulse for the previous item is already done
    always_ff @(posedge clk) begin
        if (tex_fire) begin
            fb_x          <= tex_dst_x;
            fb_y          <= tex_dst_y;
            fb_colour     <= tex_colour;    // fill colour, replaced on read data for images
            m_axil_araddr <= {tex_addr[`BLIT_ADDR_W-1:2], 2'b00};
            half_q        <= tex_addr[1];
        end
        if (r_fire) begin
            fb_colour <= half_q ? m_axil_rdata[`BLIT_AXI_DATA_W-1:`BLIT_COLOUR_W]
                                : m_axil_rdata[`BLIT_COLOUR_W-1:0];
        end
    end

endmodule

// File: hw/blit_defs.svh
`ifndef BLIT_DEFS_SVH
`define BLIT_DEFS_SVH

// widths
`define BLIT_COORD_W     16
`define BLIT_ADDR_W      32
`define BLIT_COLOUR_W    16
`define BLIT_AXI_DATA_W  32

// default framebuffer size in pixels
`define BLIT_FB_WIDTH    400
`define BLIT_FB_HEIGHT   240

`endif

// File: hw/blit_pkg.sv
`include "blit_defs.svh"

package blit_pkg;

    typedef logic [`BLIT_COORD_W-1:0]    coord_t;     // coordinate, size or stride
    typedef logic [`BLIT_ADDR_W-1:0]     addr_t;      // byte address
    typedef logic [`BLIT_COLOUR_W-1:0]   colour_t;    // rgb565
    typedef logic [`BLIT_AXI_DATA_W-1:0] axi_data_t;

    typedef enum logic {
        WALK_IDLE,
        WALKING
    } walk_state_t;

    typedef enum logic [1:0] {
        SKID_EMPTY,
        SKID_ONE,
        SKID_TWO
    } skid_state_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_WRITE
    } fetch_state_t;

endpackage

// File: hw/blit_top.sv
`timescale 1ns/1ps
`include "blit_defs.svh"

module blit_top #(
    parameter int FB_WIDTH  = `BLIT_FB_WIDTH,
    parameter int FB_HEIGHT = `BLIT_FB_HEIGHT
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  blit_pkg::coord_t     dst_x,
    input  blit_pkg::coord_t     dst_y,
    input  blit_pkg::coord_t     width,
    input  blit_pkg::coord_t     height,
    input  blit_pkg::coord_t     src_x,
    input  blit_pkg::coord_t     src_y,
    input  blit_pkg::addr_t      image_base,
    input  blit_pkg::coord_t     image_stride,
    input  logic                 mirror_x,
    input  logic                 mirror_y,
    input  logic                 fill_mode,
    input  blit_pkg::colour_t    fill_colour,

    output blit_pkg::addr_t      m_axil_araddr,
    output logic [2:0]           m_axil_arprot,
    output logic                 m_axil_arvalid,
    input  logic                 m_axil_arready,
    input  blit_pkg::axi_data_t  m_axil_rdata,
    input  logic [1:0]           m_axil_rresp,
    input  logic                 m_axil_rvalid,
    output logic                 m_axil_rready,

    output blit_pkg::coord_t     fb_x,
    output blit_pkg::coord_t     fb_y,
    output blit_pkg::colour_t    fb_colour,
    output logic                 fb_write
);

    // walker to address stage
    logic              pix_valid;
    logic              pix_ready;
    blit_pkg::coord_t  pix_src_x;
    blit_pkg::coord_t  pix_src_y;
    blit_pkg::coord_t  pix_dst_x;
    blit_pkg::coord_t  pix_dst_y;
    logic              pix_fill;
    blit_pkg::colour_t pix_colour;
    blit_pkg::addr_t   pix_base;
    blit_pkg::coord_t  pix_stride;

    // address stage to fetch
    logic              tex_valid;
    logic              tex_ready;
    blit_pkg::addr_t   tex_addr;
    blit_pkg::coord_t  tex_dst_x;
    blit_pkg::coord_t  tex_dst_y;
    logic              tex_fill;
    blit_pkg::colour_t tex_colour;

    rect_walker #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) walker0 (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .dst_x        (dst_x),
        .dst_y        (dst_y),
        .width        (width),
        .height       (height),
        .src_x        (src_x),
        .src_y        (src_y),
        .image_base   (image_base),
        .image_stride (image_stride),
        .mirror_x     (mirror_x),
        .mirror_y     (mirror_y),
        .fill_mode    (fill_mode),
        .fill_colour  (fill_colour),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pix_src_x    (pix_src_x),
        .pix_src_y    (pix_src_y),
        .pix_dst_x    (pix_dst_x),
        .pix_dst_y    (pix_dst_y),
        .pix_fill     (pix_fill),
        .pix_colour   (pix_colour),
        .pix_base     (pix_base),
        .pix_stride   (pix_stride)
    );

    texel_address addr0 (
        .clk        (clk),
        .rst        (rst),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix_src_x  (pix_src_x),
        .pix_src_y  (pix_src_y),
        .pix_dst_x  (pix_dst_x),
        .pix_dst_y  (pix_dst_y),
        .pix_fill   (pix_fill),
        .pix_colour (pix_colour),
        .pix_base   (pix_base),
        .pix_stride (pix_stride),
        .tex_valid  (tex_valid),
        .tex_ready  (tex_ready),
        .tex_addr   (tex_addr),
        .tex_dst_x  (tex_dst_x),
        .tex_dst_y  (tex_dst_y),
        .tex_fill   (tex_fill),
        .tex_colour (tex_colour)
    );

    axil_texel_fetch fetch0 (
        .clk            (clk),
        .rst            (rst),
        .tex_valid      (tex_valid),
        .tex_ready      (tex_ready),
        .tex_addr       (tex_addr),
        .tex_dst_x      (tex_dst_x),
        .tex_dst_y      (tex_dst_y),
        .tex_fill       (tex_fill),
        .tex_colour     (tex_colour),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arprot  (m_axil_arprot),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rresp   (m_axil_rresp),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready),
        .fb_x           (fb_x),
        .fb_y           (fb_y),
        .fb_colour      (fb_colour),
        .fb_write       (fb_write)
    );

endmodule

// File: hw/rect_walker.sv
`timescale 1ns/1ps
`include "blit_defs.svh"

module rect_walker #(
    parameter int FB_WIDTH  = `BLIT_FB_WIDTH,
    parameter int FB_HEIGHT = `BLIT_FB_HEIGHT
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  blit_pkg::coord_t   dst_x,
    input  blit_pkg::coord_t   dst_y,
    input  blit_pkg::coord_t   width,
    input  blit_pkg::coord_t   height,
    input  blit_pkg::coord_t   src_x,
    input  blit_pkg::coord_t   src_y,
    input  blit_pkg::addr_t    image_base,
    input  blit_pkg::coord_t   image_stride,
    input  logic               mirror_x,
    input  logic               mirror_y,
    input  logic               fill_mode,
    input  blit_pkg::colour_t  fill_colour,

    output logic               pix_valid,
    input  logic               pix_ready,
    output blit_pkg::coord_t   pix_src_x,
    output blit_pkg::coord_t   pix_src_y,
    output blit_pkg::coord_t   pix_dst_x,
    output blit_pkg::coord_t   pix_dst_y,
    output logic               pix_fill,
    output blit_pkg::colour_t  pix_colour,
    output blit_pkg::addr_t    pix_base,
    output blit_pkg::coord_t   pix_stride
);

    localparam blit_pkg::coord_t ONE = 1;

    blit_pkg::walk_state_t state;

    blit_pkg::coord_t  dst_x_q;
    blit_pkg::coord_t  dst_y_q;
    blit_pkg::coord_t  width_q;
    blit_pkg::coord_t  height_q;
    blit_pkg::coord_t  src_x_q;
    blit_pkg::coord_t  src_y_q;
    blit_pkg::addr_t   base_q;
    blit_pkg::coord_t  stride_q;
    logic              mirror_x_q;
    logic              mirror_y_q;
    logic              fill_q;
    blit_pkg::colour_t colour_q;

    blit_pkg::coord_t  x;   // walk index
    blit_pkg::coord_t  y;

    logic cmd_fire;
    logic in_bounds;
    logic step;
    logic last_x;
    logic last_y;

    assign cmd_fire = cmd_valid && cmd_ready;

    assign pix_dst_x = mirror_x_q ? dst_x_q + width_q - ONE - x : dst_x_q + x;
    assign pix_dst_y = mirror_y_q ? dst_y_q + height_q - ONE - y : dst_y_q + y;
    assign pix_src_x = src_x_q + x;
    assign pix_src_y = src_y_q + y;
    assign pix_fill   = fill_q;
    assign pix_colour = colour_q;
    assign pix_base   = base_q;
    assign pix_stride = stride_q;

    assign in_bounds = (int'(pix_dst_x) < FB_WIDTH) && (int'(pix_dst_y) < FB_HEIGHT);
    assign pix_valid = (state == blit_pkg::WALKING) && in_bounds;
    // clipped positions pass without waiting on pix_ready
    assign step   = (state == blit_pkg::WALKING) && (pix_ready || !in_bounds);
    assign last_x = (x == width_q - ONE);
    assign last_y = (y == height_q - ONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= blit_pkg::WALK_IDLE;
            cmd_ready <= 1'b0;
        end else begin
            case (state)
                blit_pkg::WALK_IDLE: begin
                    cmd_ready <= 1'b1;
                    if (cmd_fire && width != '0 && height != '0) begin
                        state     <= blit_pkg::WALKING;
                        cmd_ready <= 1'b0;
                    end
                end
                blit_pkg::WALKING: begin
                    if (step && last_x && last_y) begin
                        state     <= blit_pkg::WALK_IDLE;
                        cmd_ready <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            dst_x_q    <= dst_x;
            dst_y_q    <= dst_y;
            width_q    <= width;
            height_q   <= height;
            src_x_q    <= src_x;
            src_y_q    <= src_y;
            base_q     <= image_base;
            stride_q   <= image_stride;
            mirror_x_q <= mirror_x;
            mirror_y_q <= mirror_y;
            fill_q     <= fill_mode;
            colour_q   <= fill_colour;
            x          <= '0;
            y          <= '0;
        end else if (step) begin
            if (last_x) begin
                x <= '0;
                y <= y + ONE;   // next row
            end else begin
                x <= x + ONE;
            end
        end
    end

endmodule

// File: hw/texel_address.sv
`timescale 1ns/1ps

module texel_address (
    input  logic               clk,
    input  logic               rst,

    input  logic               pix_valid,
    output logic               pix_ready,
    input  blit_pkg::coord_t   pix_src_x,
    input  blit_pkg::coord_t   pix_src_y,
    input  blit_pkg::coord_t   pix_dst_x,
    input  blit_pkg::coord_t   pix_dst_y,
    input  logic               pix_fill,
    input  blit_pkg::colour_t  pix_colour,
    input  blit_pkg::addr_t    pix_base,
    input  blit_pkg::coord_t   pix_stride,

    output logic               tex_valid,
    input  logic               tex_ready,
    output blit_pkg::addr_t    tex_addr,
    output blit_pkg::coord_t   tex_dst_x,
    output blit_pkg::coord_t   tex_dst_y,
    output logic               tex_fill,
    output blit_pkg::colour_t  tex_colour
);

    blit_pkg::skid_state_t state;

    blit_pkg::addr_t   pix_offset;
    blit_pkg::addr_t   pix_addr;
    logic              in_fire;
    logic              out_fire;
    logic              load_out;
    logic              load_skid;
    logic              pop_skid;

    blit_pkg::addr_t   skid_addr;
    blit_pkg::coord_t  skid_dst_x;
    blit_pkg::coord_t  skid_dst_y;
    logic              skid_fill;
    blit_pkg::colour_t skid_colour;

    // pixel index within the image, then bytes at 2 per pixel
    assign pix_offset = blit_pkg::addr_t'(pix_src_x)
                      + blit_pkg::addr_t'(pix_stride) * blit_pkg::addr_t'(pix_src_y);
    assign pix_addr   = pix_base + (pix_offset << 1);

    assign pix_ready = (state != blit_pkg::SKID_TWO);
    assign tex_valid = (state != blit_pkg::SKID_EMPTY);
    assign in_fire   = pix_valid && pix_ready;
    assign out_fire  = tex_valid && tex_ready;

    assign load_out  = in_fire && (state == blit_pkg::SKID_EMPTY
                                   || (state == blit_pkg::SKID_ONE && out_fire));
    assign load_skid = in_fire && state == blit_pkg::SKID_ONE && !out_fire;
    assign pop_skid  = out_fire && state == blit_pkg::SKID_TWO;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= blit_pkg::SKID_EMPTY;
        end else begin
            case (state)
                blit_pkg::SKID_EMPTY: if (in_fire) state <= blit_pkg::SKID_ONE;
                blit_pkg::SKID_ONE: begin
                    if (in_fire && !out_fire)
                        state <= blit_pkg::SKID_TWO;
                    else if (!in_fire && out_fire)
                        state <= blit_pkg::SKID_EMPTY;
                end
                blit_pkg::SKID_TWO: if (out_fire) state <= blit_pkg::SKID_ONE;
                default: state <= blit_pkg::SKID_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            tex_addr   <= pix_addr;
            tex_dst_x  <= pix_dst_x;
            tex_dst_y  <= pix_dst_y;
            tex_fill   <= pix_fill;
            tex_colour <= pix_colour;
        end else if (pop_skid) begin
            tex_addr   <= skid_addr;
            tex_dst_x  <= skid_dst_x;
            tex_dst_y  <= skid_dst_y;
            tex_fill   <= skid_fill;
            tex_colour <= skid_colour;
        end
        if (load_skid) begin    // output stalled, park the new item
            skid_addr   <= pix_addr;
            skid_dst_x  <= pix_dst_x;
            skid_dst_y  <= pix_dst_y;
            skid_fill   <= pix_fill;
            skid_colour <= pix_colour;
        end
    end

endmodule
